//--- logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// ------------------------------------------------------------
// datapath sizing
// ------------------------------------------------------------

// width of the shared bus, registers, Y and Z
`define CPU_DATA_W 32

// general purpose registers R0..R15
`define CPU_REG_COUNT 16

// ------------------------------------------------------------
// start-up
// ------------------------------------------------------------

// word address of the first instruction fetched after reset
// and again after every start that follows a HALT
`define CPU_RESET_PC 0

`endif

//--- logic/cpuIsaPkg.sv
`include "cpu_macros.svh"

package cpuIsaPkg;

    // ------------------------------------------------------------
    // basic words
    // ------------------------------------------------------------

    typedef logic [`CPU_DATA_W-1:0] dataWord_t;                 // one bus / register word
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] regIdx_t;        // register number

    // 4-bit opcode in the top nibble of every instruction
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        SHL  = 4'd4,                                            // logical left
        SHR  = 4'd5,                                            // logical right
        LDI  = 4'd6,                                            // ra = zero-extended imm
        ST   = 4'd7,                                            // mem[imm] = ra
        HALT = 4'd8
    } opcode_t;

    // ------------------------------------------------------------
    // instruction formats
    // ------------------------------------------------------------

    // register form, ra = rb op rc
    typedef struct packed {
        opcode_t                  opcode;
        regIdx_t                  ra;                           // destination
        regIdx_t                  rb;                           // first source, goes to Y
        regIdx_t                  rc;                           // second source, on bus in T4
        logic [`CPU_DATA_W-17:0]  unused;
    } rInstr_t;

    // immediate form, used by LDI and ST
    typedef struct packed {
        opcode_t                  opcode;
        regIdx_t                  ra;                           // LDI target or ST data
        logic [`CPU_DATA_W-9:0]   imm;                          // zero-extended on the bus
    } iInstr_t;

    // same word, two decodings picked by the opcode
    typedef union packed {
        rInstr_t r;
        iInstr_t i;
    } instr_t;

endpackage

//--- logic/cpuCtrlPkg.sv
package cpuCtrlPkg;

    // ------------------------------------------------------------
    // sequencer phases
    // ------------------------------------------------------------

    typedef enum logic [2:0] {
        IDLE,                                                   // waiting for start
        T0,                                                     // PC to MAR, Z = PC + 1
        T1,                                                     // Z to PC, memory read to MDR
        T2,                                                     // MDR to IR
        T3,
        T4,
        T5,
        HALTED                                                  // parked until next start
    } phase_t;

    // who drives the single internal bus
    typedef enum logic [2:0] {
        NONE,                                                   // bus reads 0
        PC,
        MDR,
        Z,
        REG,                                                    // register selected by srcReg
        IMM                                                     // immediate from decode
    } busSrc_t;

    // ------------------------------------------------------------
    // control word, one per clock
    // ------------------------------------------------------------

    typedef struct packed {
        busSrc_t            busSrc;
        cpuIsaPkg::regIdx_t srcReg;
        cpuIsaPkg::regIdx_t dstReg;
        logic               regIn;                              // write dstReg from bus
        logic               pcIn;
        logic               marIn;
        logic               mdrInBus;
        logic               mdrInMem;                           // takes memRdata
        logic               incPc;                              // Z = bus + 1
        logic               yIn;
        logic               zIn;
        cpuIsaPkg::opcode_t aluOp;
        logic               memRead;
        logic               memWrite;
    } ctrlWord_t;

    parameter ctrlWord_t CTRL_NOP = '0;                         // nothing moves

endpackage

//--- logic/instrDecode.sv
`include "cpu_macros.svh"

module instrDecode (
    input  logic                  clock,
    input  logic                  arstN,
    input  logic                  start,                        // one-cycle pulse
    input  cpuIsaPkg::dataWord_t  bus,
    output cpuCtrlPkg::ctrlWord_t ctrl,
    output cpuIsaPkg::dataWord_t  imm,
    output logic                  halted
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    instr_t  ir;                                                // instruction register
    instr_t  busInstr;                                          // word on the bus during T2
    phase_t  phase;
    phase_t  phaseNext;
    opcode_t op;
    logic    idleLike;

    function automatic logic isAluOp(opcode_t code);
        return code inside {ADD, SUB, AND, OR, SHL, SHR};
    endfunction

    assign busInstr = bus;
    assign op       = ir.r.opcode;                              // same bits in both views
    assign idleLike = (phase == IDLE) || (phase == HALTED);
    assign halted   = (phase == HALTED);

    // reset PC is offered on imm while parked so start can reload PC
    assign imm = idleLike ? dataWord_t'(`CPU_RESET_PC) : dataWord_t'(ir.i.imm);

    // ------------------------------------------------------------
    // phase sequencer
    // ------------------------------------------------------------

    always_comb begin
        phaseNext = phase;
        case (phase)
            IDLE, HALTED: phaseNext = start ? T0 : phase;
            T0:           phaseNext = T1;
            T1:           phaseNext = T2;
            T2:           phaseNext = (busInstr.r.opcode == HALT) ? HALTED : T3;
            T3:           phaseNext = (isAluOp(op) || op == ST) ? T4 : T0; // LDI done
            T4:           phaseNext = T5;
            T5:           phaseNext = T0;
            default:      phaseNext = IDLE;
        endcase
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            phase <= IDLE;
            ir    <= '0;
        end else begin
            phase <= phaseNext;
            if (phase == T2) begin
                ir <= busInstr;                                 // MDR is on the bus now
            end
        end
    end

    // ------------------------------------------------------------
    // control word
    // ------------------------------------------------------------

    always_comb begin
        ctrl = CTRL_NOP;
        case (phase)
            IDLE, HALTED: begin
                ctrl.busSrc = IMM;                              // reset PC on the bus
                ctrl.pcIn   = start;
            end
            T0: begin
                ctrl.busSrc = PC;
                ctrl.marIn  = 1'b1;
                ctrl.incPc  = 1'b1;
                ctrl.zIn    = 1'b1;
            end
            T1: begin
                ctrl.busSrc   = Z;                              // PC + 1 back into PC
                ctrl.pcIn     = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.mdrInMem = 1'b1;
            end
            T2: ctrl.busSrc = MDR;
            T3: begin
                if (isAluOp(op)) begin
                    ctrl.busSrc = REG;                          // rb into Y
                    ctrl.srcReg = ir.r.rb;
                    ctrl.yIn    = 1'b1;
                end else if (op == LDI) begin
                    ctrl.busSrc = IMM;
                    ctrl.dstReg = ir.i.ra;
                    ctrl.regIn  = 1'b1;
                end else if (op == ST) begin
                    ctrl.busSrc = IMM;                          // store address
                    ctrl.marIn  = 1'b1;
                end
            end
            T4: begin
                if (isAluOp(op)) begin
                    ctrl.busSrc = REG;                          // rc straight into the ALU
                    ctrl.srcReg = ir.r.rc;
                    ctrl.aluOp  = op;
                    ctrl.zIn    = 1'b1;
                end else begin
                    ctrl.busSrc   = REG;                        // store data into MDR
                    ctrl.srcReg   = ir.i.ra;
                    ctrl.mdrInBus = 1'b1;
                end
            end
            T5: begin
                if (isAluOp(op)) begin
                    ctrl.busSrc = Z;
                    ctrl.dstReg = ir.r.ra;
                    ctrl.regIn  = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;                       // MAR/MDR already set up
                end
            end
            default: ctrl = CTRL_NOP;
        endcase
    end

endmodule

//--- logic/aluExecute.sv
`include "cpu_macros.svh"

module aluExecute (
    input  logic                  clock,
    input  logic                  arstN,
    input  cpuCtrlPkg::ctrlWord_t ctrl,
    input  cpuIsaPkg::dataWord_t  bus,
    output cpuIsaPkg::dataWord_t  z
);
    import cpuIsaPkg::*;

    dataWord_t                      y;                          // first operand, loaded in T3
    dataWord_t                      aluResult;
    dataWord_t                      zNext;
    logic [$clog2(`CPU_DATA_W)-1:0] shamt;

    assign shamt = bus[$clog2(`CPU_DATA_W)-1:0];                // low bits only, 0..31

    // ------------------------------------------------------------
    // ALU, Y op bus
    // ------------------------------------------------------------

    always_comb begin
        case (ctrl.aluOp)
            ADD:     aluResult = y + bus;                       // wraps mod 2^32
            SUB:     aluResult = y - bus;
            AND:     aluResult = y & bus;
            OR:      aluResult = y | bus;
            SHL:     aluResult = y << shamt;
            SHR:     aluResult = y >> shamt;                    // zero fill
            default: aluResult = '0;
        endcase
    end

    // fetch increments the PC through the same Z path
    assign zNext = ctrl.incPc ? bus + dataWord_t'(1) : aluResult;

    // ------------------------------------------------------------
    // Y and Z registers
    // ------------------------------------------------------------

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            y <= '0;
        end else if (ctrl.yIn) begin
            y <= bus;
        end
    end

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            z <= '0;
        end else if (ctrl.zIn) begin
            z <= zNext;                                         // read back in T1 or T5
        end
    end

endmodule

//--- logic/regFileBus.sv
`include "cpu_macros.svh"

module regFileBus (
    input  logic                  clock,
    input  logic                  arstN,
    input  cpuCtrlPkg::ctrlWord_t ctrl,
    input  cpuIsaPkg::dataWord_t  pc,
    input  cpuIsaPkg::dataWord_t  mdr,
    input  cpuIsaPkg::dataWord_t  z,
    input  cpuIsaPkg::dataWord_t  imm,
    output cpuIsaPkg::dataWord_t  bus
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    dataWord_t regs [`CPU_REG_COUNT];                           // R0..R15, R0 is writable too
    dataWord_t srcWord;

    assign srcWord = regs[ctrl.srcReg];

    // ------------------------------------------------------------
    // register file, one write port from the bus
    // ------------------------------------------------------------

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regIn) begin
            regs[ctrl.dstReg] <= bus;                           // LDI in T3, ALU in T5
        end
    end

    // ------------------------------------------------------------
    // bus multiplexer
    // ------------------------------------------------------------

    always_comb begin
        case (ctrl.busSrc)
            NONE:    bus = '0;
            PC:      bus = pc;
            MDR:     bus = mdr;
            Z:       bus = z;
            REG:     bus = srcWord;
            IMM:     bus = imm;                                 // zero-extended already
            default: bus = '0;
        endcase
    end

endmodule

//--- logic/memPort.sv
`include "cpu_macros.svh"

module memPort (
    input  logic                  clock,
    input  logic                  arstN,
    input  cpuCtrlPkg::ctrlWord_t ctrl,
    input  cpuIsaPkg::dataWord_t  bus,
    input  cpuIsaPkg::dataWord_t  memRdata,                     // valid with memRead
    output cpuIsaPkg::dataWord_t  pc,
    output cpuIsaPkg::dataWord_t  mdr,
    output cpuIsaPkg::dataWord_t  memAddr,
    output cpuIsaPkg::dataWord_t  memWdata,
    output logic                  memRead,
    output logic                  memWrite
);
    import cpuIsaPkg::*;

    dataWord_t mar;

    // ------------------------------------------------------------
    // PC, MAR, MDR
    // ------------------------------------------------------------

    always_ff @(posedge clock or negedge arstN) begin
        if (!arstN) begin
            pc  <= dataWord_t'(`CPU_RESET_PC);
            mar <= '0;
            mdr <= '0;
        end else begin
            if (ctrl.pcIn) begin
                pc <= bus;                                      // Z in T1, reset PC on start
            end
            if (ctrl.marIn) begin
                mar <= bus;                                     // PC in T0, address in ST T3
            end
            if (ctrl.mdrInMem) begin
                mdr <= memRdata;                                // no wait states
            end else if (ctrl.mdrInBus) begin
                mdr <= bus;                                     // store data
            end
        end
    end

    assign memAddr  = mar;
    assign memWdata = mdr;
    assign memRead  = ctrl.memRead;                             // T1 only
    assign memWrite = ctrl.memWrite;                            // ST T5 only

endmodule

//--- logic/busCpu.sv
module busCpu (
    input  logic                 clock,
    input  logic                 arstN,
    input  logic                 start,
    input  cpuIsaPkg::dataWord_t memRdata,
    output cpuIsaPkg::dataWord_t memAddr,
    output logic                 memRead,
    output logic                 memWrite,
    output cpuIsaPkg::dataWord_t memWdata,
    output logic                 halted
);
    import cpuIsaPkg::*;
    import cpuCtrlPkg::*;

    ctrlWord_t ctrl;                                            // from the sequencer
    dataWord_t bus;                                             // the single shared bus
    dataWord_t imm;
    dataWord_t pc;
    dataWord_t mdr;
    dataWord_t z;

    // ------------------------------------------------------------
    // the four datapath blocks
    // ------------------------------------------------------------

    instrDecode instrDecodeInst (
        .clock  (clock),
        .arstN  (arstN),
        .start  (start),
        .bus    (bus),
        .ctrl   (ctrl),
        .imm    (imm),
        .halted (halted)
    );

    aluExecute aluExecuteInst (
        .clock (clock),
        .arstN (arstN),
        .ctrl  (ctrl),
        .bus   (bus),
        .z     (z)
    );

    regFileBus regFileBusInst (
        .clock (clock),
        .arstN (arstN),
        .ctrl  (ctrl),
        .pc    (pc),
        .mdr   (mdr),
        .z     (z),
        .imm   (imm),
        .bus   (bus)
    );

    memPort memPortInst (
        .clock    (clock),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .bus      (bus),
        .memRdata (memRdata),
        .pc       (pc),
        .mdr      (mdr),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memRead  (memRead),
        .memWrite (memWrite)
    );

endmodule

//--- verif/busCpu_sva.sv
module busCpu_sva (
    input logic               clock,
    input logic               arstN,
    input logic               start,
    input logic               memRead,
    input logic               memWrite,
    input logic               halted,
    input cpuCtrlPkg::phase_t phase                             // sequencer state, bound inside
);
    import cpuCtrlPkg::*;

    int failCount = 0;                                          // assertion failures so far

    // ------------------------------------------------------------
    // memory strobes
    // ------------------------------------------------------------

    strobeExclusive: assert property (@(posedge clock) disable iff (!arstN)
        !(memRead && memWrite))
        else begin
            $error("memRead and memWrite high in the same cycle");
            failCount++;
        end

    writeSingleCycle: assert property (@(posedge clock) disable iff (!arstN)
        memWrite |=> !memWrite)                                 // ST T5 only
        else begin
            $error("memWrite held longer than one cycle");
            failCount++;
        end

    // halted stays up until start is taken, so this covers the whole parked time
    quietWhileHalted: assert property (@(posedge clock) disable iff (!arstN)
        halted |-> !(memRead || memWrite))
        else begin
            $error("memory strobe while halted");
            failCount++;
        end

    // ------------------------------------------------------------
    // phase order
    // ------------------------------------------------------------

    // a start while parked gives T0 first and the fetch read one cycle later
    fetchAfterStart: assert property (@(posedge clock) disable iff (!arstN)
        (phase inside {IDLE, HALTED}) && start |=> !memRead ##1 memRead)
        else begin
            $error("fetch read not in the second cycle after start");
            failCount++;
        end

endmodule

bind busCpu busCpu_sva busCpuSvaInst (
    .clock    (clock),
    .arstN    (arstN),
    .start    (start),
    .memRead  (memRead),
    .memWrite (memWrite),
    .halted   (halted),
    .phase    (instrDecodeInst.phase)
);

//--- verif/busCpu_tb.sv
`include "cpu_macros.svh"

module busCpu_tb;
    import cpuIsaPkg::*;

    localparam int MEM_WORDS  = 64;
    localparam int STORE_BASE = 'h100;                          // stores land above the program

    logic      clock;
    logic      arstN;
    logic      start;
    dataWord_t memRdata;
    dataWord_t memAddr;
    logic      memRead;
    logic      memWrite;
    dataWord_t memWdata;
    logic      halted;

    dataWord_t mem [MEM_WORDS];                                 // program memory, read only
    dataWord_t expAddr [$];                                     // expected stores, one run
    dataWord_t expData [$];
    dataWord_t fetchExp;                                        // next expected fetch address
    int        progLen;
    int        nInstr;
    int        errors;
    int        storeCount;
    int        cycleCount;
    int        limitCycles;

    busCpu busCpu_inst (
        .clock    (clock),
        .arstN    (arstN),
        .start    (start),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memWdata (memWdata),
        .halted   (halted)
    );

    assign memRdata = mem[memAddr[$clog2(MEM_WORDS)-1:0]];      // no wait states

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    // ------------------------------------------------------------
    // assembler and reference model
    // ------------------------------------------------------------

    function automatic dataWord_t asmR(opcode_t op, regIdx_t ra, regIdx_t rb, regIdx_t rc);
        instr_t w;
        w          = '0;
        w.r.opcode = op;
        w.r.ra     = ra;                                        // destination
        w.r.rb     = rb;
        w.r.rc     = rc;
        return dataWord_t'(w);
    endfunction

    function automatic dataWord_t asmI(opcode_t op, regIdx_t ra, logic [`CPU_DATA_W-9:0] imm);
        instr_t w;
        w          = '0;
        w.i.opcode = op;
        w.i.ra     = ra;
        w.i.imm    = imm;
        return dataWord_t'(w);
    endfunction

    task automatic appendWord(dataWord_t word);
        mem[progLen] = word;
        progLen++;
    endtask

    // runs the ISA on a 16-entry model, fills the expected stores, returns instructions done
    function automatic int refRun();
        dataWord_t regs [`CPU_REG_COUNT];
        instr_t    w;
        dataWord_t pcModel;
        dataWord_t a;
        dataWord_t b;
        int        executed;
        bit        running;
        foreach (regs[i]) regs[i] = '0;
        pcModel  = `CPU_RESET_PC;
        executed = 0;
        running  = 1'b1;
        expAddr.delete();
        expData.delete();
        while (running && executed < MEM_WORDS) begin
            w = mem[pcModel[$clog2(MEM_WORDS)-1:0]];
            pcModel++;
            executed++;
            a = regs[w.r.rb];
            b = regs[w.r.rc];
            case (w.r.opcode)
                ADD:     regs[w.r.ra] = a + b;                  // mod 2^32
                SUB:     regs[w.r.ra] = a - b;
                AND:     regs[w.r.ra] = a & b;
                OR:      regs[w.r.ra] = a | b;
                SHL:     regs[w.r.ra] = a << b[4:0];            // only low 5 bits count
                SHR:     regs[w.r.ra] = a >> b[4:0];
                LDI:     regs[w.i.ra] = dataWord_t'(w.i.imm);   // zero-extended
                ST: begin
                    expAddr.push_back(dataWord_t'(w.i.imm));
                    expData.push_back(regs[w.i.ra]);
                end
                default: running = 1'b0;                        // HALT
            endcase
        end
        return executed;
    endfunction

    task automatic buildProgram();
        dataWord_t smallVal;
        dataWord_t bigVal;
        dataWord_t shiftMax;
        dataWord_t shiftWrap;
        smallVal  = $urandom & 32'h0000_00FF;                   // R2 < R3 forces a borrow
        bigVal    = ($urandom & 32'h00FF_FFFF) | 32'h0080_0000;
        shiftMax  = ($urandom & 32'h00FF_FFFF) | 32'h0000_001F; // amount 31
        shiftWrap = ($urandom & 32'h00FF_FFE0) | 32'h0000_0020; // 32 or more, amount 0
        appendWord(asmI(LDI, 2, smallVal[23:0]));
        appendWord(asmI(LDI, 3, bigVal[23:0]));
        appendWord(asmI(LDI, 4, shiftMax[23:0]));
        appendWord(asmI(LDI, 5, shiftWrap[23:0]));
        appendWord(asmR(SUB, 1, 2, 3));                         // R1 = R2 - R3
        appendWord(asmR(ADD, 6, 2, 3));
        appendWord(asmR(AND, 7, 3, 4));
        appendWord(asmR(OR, 8, 2, 4));
        appendWord(asmR(SHL, 9, 3, 4));
        appendWord(asmR(SHR, 10, 3, 4));
        appendWord(asmR(SHL, 11, 4, 5));
        appendWord(asmR(SHR, 12, 3, 2));
        for (int k = 1; k <= 12; k++) begin
            appendWord(asmI(ST, regIdx_t'(k), 24'(STORE_BASE + k)));
        end
        appendWord(asmI(HALT, 0, 0));
    endtask

    // ------------------------------------------------------------
    // checks
    // ------------------------------------------------------------

    task automatic checkWord(string name, dataWord_t got, dataWord_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkAddr(string name, dataWord_t got, dataWord_t exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // sampled on the rising edge, before the DUT registers move
    always @(posedge clock) begin : compareBus
        int idx;
        if (arstN) begin
            if (start) begin
                fetchExp = `CPU_RESET_PC;                       // every run refetches from reset PC
            end
            if (memRead) begin
                checkAddr("memAddr (fetch)", memAddr, fetchExp);
                fetchExp = fetchExp + 1;
            end
            if (memWrite) begin
                idx = storeCount % expData.size();              // second run repeats the list
                checkAddr("memAddr (store)", memAddr, expAddr[idx]);
                checkWord("memWdata", memWdata, expData[idx]);
                storeCount++;
            end
            if (halted && (memRead || memWrite)) begin
                errors++;
                $display("memory strobe seen while halted at time %0t", $time);
            end
        end
    end

    // ------------------------------------------------------------
    // timeout
    // ------------------------------------------------------------

    initial begin
        cycleCount = 0;
        wait (limitCycles > 0);
        while (cycleCount < limitCycles) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: no end of test after %0d cycles", cycleCount);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic runProgram();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        do @(negedge clock); while (!halted);                   // timeout guards this loop
        repeat (3) @(posedge clock);                            // parked, stray strobes show up
    endtask

    initial begin
        arstN      = 1'b0;
        start      = 1'b0;
        errors     = 0;
        storeCount = 0;
        progLen    = 0;
        fetchExp   = `CPU_RESET_PC;
        void'($urandom(77));
        foreach (mem[i]) mem[i] = {16'hD0D0, 16'(i)};           // unused words, opcode not valid
        buildProgram();
        nInstr      = refRun();
        limitCycles = 2 * (6 * nInstr + 20) + 8;                // two runs plus reset
        repeat (4) @(posedge clock);
        arstN <= 1'b1;
        @(negedge clock);
        checkFlag("memRead", memRead, 1'b0);
        checkFlag("memWrite", memWrite, 1'b0);
        checkFlag("halted", halted, 1'b0);
        for (int run = 1; run <= 2; run++) begin
            runProgram();
            if (storeCount != run * expData.size()) begin
                errors++;
                $display("run %0d ended with %0d stores, %0d were expected",
                         run, storeCount, run * expData.size());
            end
        end
        errors += busCpu_inst.busCpuSvaInst.failCount;          // bound assertion failures
        $display("errors %0d, stores %0d, instructions per run %0d", errors, storeCount, nInstr);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/cpuIsaPkg.sv
logic/cpuCtrlPkg.sv
logic/instrDecode.sv
logic/aluExecute.sv
logic/regFileBus.sv
logic/memPort.sv
logic/busCpu.sv
verif/busCpu_sva.sv
verif/busCpu_tb.sv
